// ==== include/ntm_defs.svh ====
// Sizing macros for the vector adder, included by the packages, the FIFO and the testbench
`ifndef NTM_DEFS_SVH
`define NTM_DEFS_SVH

// Element width in bits
`define NTM_DATA_SIZE 16

// Vector length and status count width
`define NTM_COUNT_W 8

// Result buffer entries
`define NTM_FIFO_DEPTH 8

`endif

// ==== src/ntm_arith_pkg.sv ====
// Arithmetic types shared by the producer, scalar adder, buffer and framer
`include "ntm_defs.svh"

package ntm_arith_pkg;

  ////////////////////////////////////////
  // Element and length types
  ////////////////////////////////////////

  // One vector element or modulus
  typedef logic [`NTM_DATA_SIZE-1:0] word_t;

  // Vector length or element count
  typedef logic [`NTM_COUNT_W-1:0] count_t;

  // Operation select, sampled at start
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } op_t;

endpackage

// ==== src/ntm_stream_pkg.sv ====
// Output stream types, the status layout and the two views of an output word
`include "ntm_defs.svh"

package ntm_stream_pkg;

  ////////////////////////////////////////
  // Status word
  ////////////////////////////////////////

  // Count in the low bits, zeros above
  typedef struct packed {
    logic [`NTM_DATA_SIZE-`NTM_COUNT_W-1:0] pad;
    ntm_arith_pkg::count_t                  count;
  } status_t;

  ////////////////////////////////////////
  // Output word
  ////////////////////////////////////////

  // Same bits, read as an element result or as the closing status
  // out_is_status selects the view
  typedef union packed {
    ntm_arith_pkg::word_t element;
    status_t              status;
  } out_word_u;

endpackage

// ==== src/ntm_scalar_adder.sv ====
// Multi-cycle modular add/subtract of one element pair, used by the vector producer
`timescale 1ns/1ps

module ntm_scalar_adder (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  ntm_arith_pkg::op_t   operation,
  input  ntm_arith_pkg::word_t modulo,
  input  ntm_arith_pkg::word_t data_a,
  input  ntm_arith_pkg::word_t data_b,
  output logic                 ready,
  output ntm_arith_pkg::word_t data_out
);

  // Two guard bits: one for the carry, one for the sign
  localparam int ACC_W = $bits(ntm_arith_pkg::word_t) + 2;

  logic                    busy;
  ntm_arith_pkg::word_t    mod_r;
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] mod_ext;
  logic signed [ACC_W-1:0] a_ext;
  logic signed [ACC_W-1:0] b_ext;
  logic                    in_range;

  // Zero-extend so the unsigned inputs stay non-negative
  assign mod_ext = signed'({2'b00, mod_r});
  assign a_ext   = signed'({2'b00, data_a});
  assign b_ext   = signed'({2'b00, data_b});

  // Done once 0 <= acc < m
  assign in_range = !acc[ACC_W-1] && (acc < mod_ext);

  // Result held in the working register until next start
  assign data_out = acc[ACC_W-3:0];

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy <= 1'b1;
      end else if (busy && in_range) begin
        // One-cycle done pulse
        busy  <= 1'b0;
        ready <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Working register
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      mod_r <= modulo;
      acc   <= (operation == ntm_arith_pkg::OP_SUB) ? (a_ext - b_ext) : (a_ext + b_ext);
    end else if (busy) begin
      // One correction step per cycle
      if (acc[ACC_W-1]) begin
        acc <= acc + mod_ext;
      end else if (acc >= mod_ext) begin
        acc <= acc - mod_ext;
      end
    end
  end

endmodule

// ==== src/ntm_vector_adder.sv ====
// Producer that collects element pairs, runs the scalar adder and pushes results into the buffer
`timescale 1ns/1ps

module ntm_vector_adder (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  ntm_arith_pkg::count_t size,
  input  ntm_arith_pkg::op_t    operation,
  input  ntm_arith_pkg::word_t  modulo,
  input  logic                  data_a_enable,
  input  logic                  data_b_enable,
  input  ntm_arith_pkg::word_t  data_a,
  input  ntm_arith_pkg::word_t  data_b,
  input  logic                  full,
  output logic                  ready,
  output logic                  wr_en,
  output ntm_arith_pkg::word_t  wr_data,
  output logic                  wr_last
);

  // FSM encoding
  localparam logic [1:0] STARTER_STATE = 2'd0;
  localparam logic [1:0] INPUT_STATE   = 2'd1;
  localparam logic [1:0] ENDER_STATE   = 2'd2;

  logic [1:0]            state;
  ntm_arith_pkg::count_t index;
  logic                  a_ok;
  logic                  b_ok;
  logic                  done;

  // Per-vector settings, sampled at start
  ntm_arith_pkg::count_t size_r;
  ntm_arith_pkg::op_t    op_r;
  ntm_arith_pkg::word_t  mod_r;

  // Operand latches
  ntm_arith_pkg::word_t  a_r;
  ntm_arith_pkg::word_t  b_r;

  // Scalar adder handshake
  logic                  add_start;
  logic                  add_ready;
  ntm_arith_pkg::word_t  add_out;

  ////////////////////////////////////////
  // Buffer write
  ////////////////////////////////////////

  // Result stays in the adder until the buffer has room
  assign wr_en   = (state == ENDER_STATE) && done && !full;
  assign wr_data = add_out;
  assign wr_last = (index == size_r - 1'b1);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= STARTER_STATE;
      index     <= '0;
      a_ok      <= 1'b0;
      b_ok      <= 1'b0;
      done      <= 1'b0;
      add_start <= 1'b0;
      ready     <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        STARTER_STATE: begin
          if (start) begin
            index <= '0;
            a_ok  <= 1'b0;
            b_ok  <= 1'b0;
            state <= INPUT_STATE;
          end
        end
        INPUT_STATE: begin
          // First strobe of each operand wins
          if (data_a_enable && !a_ok) begin
            a_ok <= 1'b1;
          end
          if (data_b_enable && !b_ok) begin
            b_ok <= 1'b1;
          end
          if (a_ok && b_ok) begin
            add_start <= 1'b1;
            a_ok      <= 1'b0;
            b_ok      <= 1'b0;
            state     <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          add_start <= 1'b0;
          if (add_ready) begin
            done <= 1'b1;
          end
          if (wr_en) begin
            done <= 1'b0;
            if (wr_last) begin
              // Vector complete
              ready <= 1'b1;
              state <= STARTER_STATE;
            end else begin
              index <= index + 1'b1;
              state <= INPUT_STATE;
            end
          end
        end
        default: begin
          state <= STARTER_STATE;
        end
      endcase
    end
  end

  // Settings and operands
  always_ff @(posedge CLK) begin
    if (state == STARTER_STATE && start) begin
      size_r <= size;
      op_r   <= operation;
      mod_r  <= modulo;
    end
    if (state == INPUT_STATE && data_a_enable && !a_ok) begin
      a_r <= data_a;
    end
    if (state == INPUT_STATE && data_b_enable && !b_ok) begin
      b_r <= data_b;
    end
  end

  ntm_scalar_adder i_scalar_adder (
    .CLK       (CLK),
    .RST       (RST),
    .start     (add_start),
    .operation (op_r),
    .modulo    (mod_r),
    .data_a    (a_r),
    .data_b    (b_r),
    .ready     (add_ready),
    .data_out  (add_out)
  );

endmodule

// ==== src/ntm_result_fifo.sv ====
// Synchronous FIFO between producer and framer, holding results with their last flags
`timescale 1ns/1ps
`include "ntm_defs.svh"

module ntm_result_fifo #(
  parameter int DEPTH = `NTM_FIFO_DEPTH
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 wr_en,
  input  ntm_arith_pkg::word_t wr_data,
  input  logic                 wr_last,
  input  logic                 rd_en,
  output logic                 full,
  output logic                 empty,
  output ntm_arith_pkg::word_t rd_data,
  output logic                 rd_last
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset
  ntm_arith_pkg::word_t mem_data [DEPTH];
  logic                 mem_last [DEPTH];

  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;
  logic             wr_fire;
  logic             rd_fire;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign wr_fire = wr_en && !full;
  assign rd_fire = rd_en && !empty;

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      // Wrap at DEPTH
      if (wr_fire) begin
        wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      end
      if (rd_fire) begin
        rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
      end
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write port and registered read port
  always_ff @(posedge CLK) begin
    if (wr_fire) begin
      mem_data[wptr] <= wr_data;
      mem_last[wptr] <= wr_last;
    end
    if (rd_fire) begin
      rd_data <= mem_data[rptr];
      rd_last <= mem_last[rptr];
    end
  end

endmodule

// ==== src/ntm_stream_framer.sv ====
// Consumer that drains the result FIFO and closes every vector with a status word
`timescale 1ns/1ps

module ntm_stream_framer (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      empty,
  input  ntm_arith_pkg::word_t      rd_data,
  input  logic                      rd_last,
  input  logic                      drain_hold,
  output logic                      rd_en,
  output logic                      out_valid,
  output logic                      out_is_status,
  output ntm_stream_pkg::out_word_u out_word
);

  logic                  pop_d;
  logic                  status_q;
  logic                  status_pending;
  ntm_arith_pkg::count_t count;

  // Last element on the read port, status goes out next cycle
  assign status_pending = pop_d && rd_last;

  // Hold off a pop that would collide with the status slot
  assign rd_en = !empty && !drain_hold && !status_pending;

  assign out_valid     = pop_d || status_q;
  assign out_is_status = status_q;

  ////////////////////////////////////////
  // Output word
  ////////////////////////////////////////

  always_comb begin
    out_word = '0;
    if (status_q) begin
      out_word.status.pad   = '0;
      out_word.status.count = count;
    end else begin
      out_word.element = rd_data;
    end
  end

  ////////////////////////////////////////
  // Pop tracking and element count
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pop_d    <= 1'b0;
      status_q <= 1'b0;
      count    <= '0;
    end else begin
      pop_d    <= rd_en;
      status_q <= status_pending;
      if (pop_d) begin
        count <= count + 1'b1;
      end else if (status_q) begin
        // Start the next vector from zero
        count <= '0;
      end
    end
  end

endmodule

// ==== src/ntm_vector_adder_top.sv ====
// Top level of the modular vector adder: producer, result FIFO and stream framer
`timescale 1ns/1ps

module ntm_vector_adder_top (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  ntm_arith_pkg::count_t     size,
  input  ntm_arith_pkg::op_t        operation,
  input  ntm_arith_pkg::word_t      modulo,
  input  logic                      data_a_enable,
  input  ntm_arith_pkg::word_t      data_a,
  input  logic                      data_b_enable,
  input  ntm_arith_pkg::word_t      data_b,
  input  logic                      drain_hold,
  output logic                      ready,
  output logic                      out_valid,
  output logic                      out_is_status,
  output ntm_stream_pkg::out_word_u out_word
);

  // Producer to FIFO
  logic                 wr_en;
  ntm_arith_pkg::word_t wr_data;
  logic                 wr_last;
  logic                 full;

  // FIFO to framer
  logic                 rd_en;
  logic                 empty;
  ntm_arith_pkg::word_t rd_data;
  logic                 rd_last;

  ntm_vector_adder i_producer (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size          (size),
    .operation     (operation),
    .modulo        (modulo),
    .data_a_enable (data_a_enable),
    .data_b_enable (data_b_enable),
    .data_a        (data_a),
    .data_b        (data_b),
    .full          (full),
    .ready         (ready),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .wr_last       (wr_last)
  );

  ntm_result_fifo i_fifo (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .wr_last (wr_last),
    .rd_en   (rd_en),
    .full    (full),
    .empty   (empty),
    .rd_data (rd_data),
    .rd_last (rd_last)
  );

  ntm_stream_framer i_framer (
    .CLK           (CLK),
    .RST           (RST),
    .empty         (empty),
    .rd_data       (rd_data),
    .rd_last       (rd_last),
    .drain_hold    (drain_hold),
    .rd_en         (rd_en),
    .out_valid     (out_valid),
    .out_is_status (out_is_status),
    .out_word      (out_word)
  );

endmodule

// ==== testbench/ntm_vector_adder_tb.sv ====
// Self-checking testbench for the vector adder top level, run from the vector file
`timescale 1ns/1ps
`include "ntm_defs.svh"

module ntm_vector_adder_tb;

  localparam int MEM_WORDS  = 512;
  // Cycles of full buffer before drain_hold drops
  localparam int HOLD_STALL = 16;

  logic                      CLK = 1'b0;
  logic                      RST;
  logic                      start;
  ntm_arith_pkg::count_t     size;
  ntm_arith_pkg::op_t        operation;
  ntm_arith_pkg::word_t      modulo;
  logic                      data_a_enable;
  ntm_arith_pkg::word_t      data_a;
  logic                      data_b_enable;
  ntm_arith_pkg::word_t      data_b;
  logic                      drain_hold;
  logic                      ready;
  logic                      out_valid;
  logic                      out_is_status;
  ntm_stream_pkg::out_word_u out_word;

  // Vector file image
  logic [`NTM_DATA_SIZE-1:0] test_mem [0:MEM_WORDS-1];

  // Captured output stream
  ntm_stream_pkg::out_word_u out_q [$];
  logic                      flag_q [$];
  int                        ready_count  = 0;
  int                        status_seen  = 0;
  int                        limit_cycles = 0;
  integer                    seed         = 32'h548d_0a37;

  // 8 ns period
  always #4 CLK = ~CLK;

  ntm_vector_adder_top i_dut (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size          (size),
    .operation     (operation),
    .modulo        (modulo),
    .data_a_enable (data_a_enable),
    .data_a        (data_a),
    .data_b_enable (data_b_enable),
    .data_b        (data_b),
    .drain_hold    (drain_hold),
    .ready         (ready),
    .out_valid     (out_valid),
    .out_is_status (out_is_status),
    .out_word      (out_word)
  );

  ////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////

  // Outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (out_valid) begin
        out_q.push_back(out_word);
        flag_q.push_back(out_is_status);
        if (out_is_status) begin
          status_seen = status_seen + 1;
        end
      end
      if (ready) begin
        ready_count = ready_count + 1;
      end
    end
  end

  // Armed once the element total is known
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_element(input logic is_status, input ntm_arith_pkg::word_t got,
                               input ntm_arith_pkg::word_t exp, input int idx);
    if (is_status) begin
      fail_run($sformatf("ERR t=%0t: element %0d arrived as a status word", $time, idx));
    end else if (got !== exp) begin
      fail_run($sformatf("ERR t=%0t: element %0d is %h, expected %h", $time, idx, got, exp));
    end
  endtask

  task automatic check_status(input logic is_status, input ntm_stream_pkg::status_t got,
                              input ntm_stream_pkg::status_t exp);
    if (!is_status) begin
      fail_run($sformatf("ERR t=%0t: element word where the status word belongs", $time));
    end else if (got !== exp) begin
      fail_run($sformatf("ERR t=%0t: status is %h, expected %h", $time, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic start_vector(input ntm_arith_pkg::op_t op, input ntm_arith_pkg::word_t m,
                              input ntm_arith_pkg::count_t n, input logic hold);
    @(posedge CLK);
    start      <= 1'b1;
    operation  <= op;
    modulo     <= m;
    size       <= n;
    drain_hold <= hold;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // Strobe a and then b after gap cycles (0 means same cycle)
  task automatic strobe_pair(input ntm_arith_pkg::word_t a, input ntm_arith_pkg::word_t b,
                             input int gap);
    @(posedge CLK);
    data_a        <= a;
    data_a_enable <= 1'b1;
    if (gap == 0) begin
      data_b        <= b;
      data_b_enable <= 1'b1;
    end
    @(posedge CLK);
    data_a_enable <= 1'b0;
    if (gap == 0) begin
      data_b_enable <= 1'b0;
    end else begin
      repeat (gap - 1) @(posedge CLK);
      data_b        <= b;
      data_b_enable <= 1'b1;
      @(posedge CLK);
      data_b_enable <= 1'b0;
    end
  endtask

  // Producer write marks the pair as consumed
  // a stall on full releases drain_hold after a while
  task automatic wait_write(inout logic full_seen);
    logic written;
    int   stall;
    written = 1'b0;
    stall   = 0;
    while (!written) begin
      @(negedge CLK);
      if (i_dut.full) begin
        full_seen = 1'b1;
      end
      if (i_dut.wr_en) begin
        written = 1'b1;
      end else if (drain_hold && i_dut.full) begin
        stall = stall + 1;
        if (stall == HOLD_STALL) begin
          @(posedge CLK);
          drain_hold <= 1'b0;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int                        n_vec;
    int                        p;
    int                        total;
    int                        gap;
    logic                      hold;
    logic                      full_seen;
    logic                      f;
    ntm_arith_pkg::count_t     vsize;
    ntm_arith_pkg::word_t      exp_q [$];
    ntm_stream_pkg::out_word_u w;
    ntm_stream_pkg::status_t   exp_status;

    // All inputs idle and reset held
    RST           = 1'b1;
    start         = 1'b0;
    size          = '0;
    operation     = ntm_arith_pkg::OP_ADD;
    modulo        = '0;
    data_a_enable = 1'b0;
    data_a        = '0;
    data_b_enable = 1'b0;
    data_b        = '0;
    drain_hold    = 1'b0;

    $readmemh("testbench/ntm_vector_adder_tests.txt", test_mem);
    if ($isunknown(test_mem[0]) || test_mem[0] == '0) begin
      fail_run("The test vector file could not be read or holds no vectors");
    end
    n_vec = int'(test_mem[0]);

    // Watchdog budget of 200 cycles per element plus 1000
    total = 0;
    p     = 1;
    for (int v = 0; v < n_vec; v++) begin
      total = total + int'(test_mem[p+2]);
      p     = p + 4 + 3 * int'(test_mem[p+2]);
    end
    limit_cycles = 200 * total + 1000;

    repeat (3) @(posedge CLK);
    RST <= 1'b0;

    p = 1;
    for (int v = 0; v < n_vec; v++) begin
      vsize     = ntm_arith_pkg::count_t'(test_mem[p+2]);
      hold      = test_mem[p+3][0];
      full_seen = 1'b0;
      exp_q.delete();
      start_vector(ntm_arith_pkg::op_t'(test_mem[p][0]), test_mem[p+1], vsize, hold);
      p = p + 4;

      for (int e = 0; e < int'(vsize); e++) begin
        exp_q.push_back(test_mem[p+2]);
        gap = $unsigned($random(seed)) % 4;
        strobe_pair(test_mem[p], test_mem[p+1], gap);
        wait_write(full_seen);
        p = p + 3;
      end

      // Done pulse after the last write and then a full drain
      while (ready_count < v + 1) @(negedge CLK);
      @(posedge CLK);
      drain_hold <= 1'b0;
      while (status_seen < v + 1) @(negedge CLK);

      if (hold && int'(vsize) > `NTM_FIFO_DEPTH && !full_seen) begin
        fail_run("The buffer never filled while drain_hold was high");
      end
      if (ready_count != v + 1) begin
        fail_run($sformatf("ERR t=%0t: %0d ready pulses after vector %0d", $time,
                           ready_count, v));
      end

      // Elements in order and then one status word
      for (int e = 0; e < int'(vsize); e++) begin
        w = out_q.pop_front();
        f = flag_q.pop_front();
        check_element(f, w.element, exp_q[e], e);
      end
      exp_status.pad   = '0;
      exp_status.count = vsize;
      w = out_q.pop_front();
      f = flag_q.pop_front();
      check_status(f, w.status, exp_status);
    end

    repeat (10) @(posedge CLK);
    if (ready_count == n_vec && out_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run($sformatf("ERR t=%0t: %0d ready pulses and %0d extra words after %0d vectors",
                         $time, ready_count, out_q.size(), n_vec));
    end
  end

endmodule

// ==== build.f ====
+incdir+include
src/ntm_arith_pkg.sv
src/ntm_stream_pkg.sv
src/ntm_scalar_adder.sv
src/ntm_vector_adder.sv
src/ntm_result_fifo.sv
src/ntm_stream_framer.sv
src/ntm_vector_adder_top.sv
testbench/ntm_vector_adder_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module ntm_vector_adder_tb -o ntm_sim

./obj_dir/ntm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== testbench/ntm_vector_adder_tests.txt ====
// Vector count, then per vector a line of: op modulus size hold (op 0 is add, 1 is sub)
// followed by one line per element of: a b expected, all values hex
0007
// Add, operands below the modulus
0000 0061 0004 0000
0010 0020 0030
0050 0030 001F
0060 0060 005F
0000 0000 0000
// Subtract with b above a
0001 00FB 0003 0000
0005 0010 00F0
0000 00FA 0001
0064 0014 0050
// Add, operands at or above the modulus
0000 1000 0003 0000
FFFF F000 0FFF
1000 0000 0000
2345 1234 0579
// Subtract, many correction steps
0001 0007 0002 0000
0100 0003 0001
0004 0041 0002
// Single element vectors
0000 0065 0001 0000
0032 0040 000D
0001 0065 0001 0000
0001 0002 0064
// Output held until the buffer fills
0000 03E8 000B 0001
0064 00C8 012C
01F4 01F4 0000
0258 0191 0001
0001 0002 0003
03E7 03E7 03E6
0123 0045 0168
0300 0100 0018
0010 0011 0021
07D0 0005 0005
0200 0200 0018
0042 0024 0066
